//--- list.f
src/msx_cart_pkg.sv
src/msx_segment_ram.sv
src/msx_bus_sync.sv
src/msx_mapper.sv
src/msx_cart_top.sv
sim/msx_cart_assertions.sv
sim/msx_cart_tb.sv

//--- run.sh
#!/bin/sh
# build and run the mapper cartridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module msx_cart_tb -f list.f \
	-Mdir obj_dir -o msx_cart_sim

# exit status of the simulation is the test result
./obj_dir/msx_cart_sim

//--- sim/msx_cart_tb.sv
/*
 * testbench for the msx mapper cartridge
 * runs slot cycles against the top level and checks every read
 * against a model of the segment registers and the mapped ram
 */

`timescale 1ns/1ps

module msx_cart_tb;
	import msx_cart_pkg::*;

	localparam int unsigned seed = 32'h358fb308;
	localparam int reset_cycles = 10;
	// strobe low time and idle gap of one slot cycle
	localparam int hold_cycles = 8;
	localparam int idle_cycles = 3;
	localparam int n_seg_writes = 16;
	localparam int n_mem_writes = 24;
	localparam int n_unclaimed = 8;
	// slot cycles over all steps
	localparam int planned_accesses = 16 + 2 * n_seg_writes + 4 * n_mem_writes + 4 * n_unclaimed;
	localparam int planned_cycles = reset_cycles
		+ planned_accesses * (hold_cycles + idle_cycles + 1);
	localparam int timeout_cycles = planned_cycles * 20 + 2000;

	logic clk;
	logic n_reset;
	logic [15:0] adr;
	logic [7:0] i_data;
	logic [7:0] o_data;
	logic is_output;
	logic is_output_d;
	logic n_sltsl;
	logic n_rd;
	logic n_wr;
	logic n_ioreq;
	logic n_mereq;

	// model state
	logic [seg_bits-1:0] model_seg [4];
	logic [7:0] model_ram [bit [ram_addr_bits-1:0]];
	// cpu addresses of the memory writes kept for later readback
	logic [15:0] written [$];

	msx_cart_top msx_cart_top_i (
		.clk(clk),
		.n_reset(n_reset),
		.adr(adr),
		.i_data(i_data),
		.o_data(o_data),
		.is_output(is_output),
		.is_output_d(is_output_d),
		.n_sltsl(n_sltsl),
		.n_rd(n_rd),
		.n_wr(n_wr),
		.n_ioreq(n_ioreq),
		.n_mereq(n_mereq)
	);

	bind msx_cart_top msx_cart_assertions msx_cart_assertions_i (
		.clk(clk),
		.n_reset(n_reset),
		.adr(adr),
		.n_sltsl(n_sltsl),
		.n_rd(n_rd),
		.n_ioreq(n_ioreq),
		.n_mereq(n_mereq),
		.is_output(is_output),
		.is_output_d(is_output_d)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// failure reporting and checks
	// --------------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else
			fail_run($sformatf("ERR %0t %s got %02h expected %02h", $time, name, got, exp));
	endtask

	// mapped ram byte that a cpu address reaches
	function automatic bit [ram_addr_bits-1:0] ram_index(input logic [15:0] a);
		return {model_seg[a[15:14]], a[13:0]};
	endfunction

	// random address in page 1 or page 2
	function automatic logic [15:0] random_mem_addr();
		logic [1:0] page;
		page = ($urandom % 2 == 0) ? 2'd1 : 2'd2;
		return {page, 14'($urandom)};
	endfunction

	// --------------------------------------------------
	// slot cycles
	// --------------------------------------------------
	// i/o cycles leave the slot select idle
	task automatic drive_select(input logic io);
		if (io) begin
			n_ioreq = 1'b0;
		end else begin
			n_sltsl = 1'b0;
			n_mereq = 1'b0;
		end
	endtask

	task automatic release_strobes();
		n_sltsl = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_ioreq = 1'b1;
		n_mereq = 1'b1;
	endtask

	task automatic slot_write(input logic io, input logic [15:0] a, input logic [7:0] d);
		@(negedge clk);
		adr = a;
		i_data = d;
		drive_select(io);
		n_wr = 1'b0;
		repeat (hold_cycles) @(negedge clk);
		release_strobes();
		repeat (idle_cycles) @(negedge clk);
	endtask

	// data is taken while the cartridge drives the slot
	task automatic slot_read(input logic io, input logic [15:0] a,
			output logic [7:0] d, output logic seen);
		@(negedge clk);
		adr = a;
		drive_select(io);
		n_rd = 1'b0;
		d = 8'h00;
		seen = 1'b0;
		repeat (hold_cycles) begin
			@(negedge clk);
			if (is_output) begin
				seen = 1'b1;
				d = o_data;
			end
		end
		release_strobes();
		repeat (idle_cycles) @(negedge clk);
	endtask

	// --------------------------------------------------
	// mapper level accesses
	// --------------------------------------------------
	task automatic write_port(input logic [1:0] p, input logic [7:0] d);
		slot_write(1'b1, {8'($urandom), mapper_port_base[7:2], p}, d);
		model_seg[p] = d[seg_bits-1:0];
	endtask

	// unused upper bits of a segment register read as 1
	task automatic read_port(input logic [1:0] p);
		logic [7:0] got;
		logic seen;
		slot_read(1'b1, {8'($urandom), mapper_port_base[7:2], p}, got, seen);
		assert (seen) else fail_run("a mapper port read drove no data onto the slot");
		check_byte("o_data", got, 8'hf8 | 8'(model_seg[p]));
	endtask

	task automatic write_mem(input logic [15:0] a, input logic [7:0] d);
		slot_write(1'b0, a, d);
		model_ram[ram_index(a)] = d;
		written.push_back(a);
	endtask

	// bytes never written have no model value and are only read
	task automatic check_mem(input logic [15:0] a);
		logic [7:0] got;
		logic seen;
		slot_read(1'b0, a, got, seen);
		assert (seen) else fail_run("a memory read in page 1 or 2 drove no data onto the slot");
		if (model_ram.exists(ram_index(a))) begin
			check_byte("o_data", got, model_ram[ram_index(a)]);
		end
	endtask

	task automatic check_unclaimed_read(input logic io, input logic [15:0] a);
		logic [7:0] got;
		logic seen;
		slot_read(io, a, got, seen);
		assert (!seen) else fail_run("is_output went high on a read outside the mapper");
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		int unsigned seed_value;
		logic [15:0] a;
		logic [7:0] d;
		logic [7:0] got;
		logic seen;
		logic [seg_bits-1:0] s;
		seed_value = $urandom(seed);
		n_reset = 1'b0;
		adr = 16'h0000;
		i_data = 8'h00;
		release_strobes();
		for (int i = 0; i < 4; i++) begin
			model_seg[i] = seg_bits'(3 - i);
		end
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		n_reset = 1'b1;

		// reset state and power-on segment map
		check_byte("is_output", {7'd0, is_output}, 8'h00);
		check_byte("is_output_d", {7'd0, is_output_d}, 8'h00);
		check_byte("o_data", o_data, 8'h00);
		for (int p = 0; p < 4; p++) begin
			read_port(2'(p));
		end

		// segment registers written and read back
		repeat (n_seg_writes) begin
			a[1:0] = 2'($urandom);
			write_port(a[1:0], 8'($urandom));
			read_port(a[1:0]);
		end

		// ram through pages 1 and 2
		repeat (n_mem_writes) begin
			write_mem(random_mem_addr(), 8'($urandom));
		end
		foreach (written[i]) begin
			check_mem(written[i]);
		end

		// one segment seen through page 1 and then page 2
		s = seg_bits'($urandom);
		write_port(2'd1, {5'($urandom), s});
		a = {2'd1, 14'($urandom)};
		d = 8'($urandom);
		write_mem(a, d);
		write_port(2'd2, {5'($urandom), s});
		slot_read(1'b0, {2'd2, a[13:0]}, got, seen);
		assert (seen) else fail_run("the aliased read in page 2 drove no data onto the slot");
		check_byte("o_data", got, d);

		// page 0 shadows page 1 and page 3 shadows page 2
		write_port(2'd0, 8'(model_seg[1]));
		write_port(2'd3, 8'(model_seg[2]));
		foreach (written[i]) begin
			a = written[i];
			slot_write(1'b0, {(a[15:14] == 2'd1) ? 2'd0 : 2'd3, a[13:0]}, 8'($urandom));
		end
		repeat (n_unclaimed) begin
			check_unclaimed_read(1'b0, {2'd0, 14'($urandom)});
			check_unclaimed_read(1'b0, {2'd3, 14'($urandom)});
			a = {8'($urandom), 8'($urandom % 252)};
			check_unclaimed_read(1'b1, a);
			slot_write(1'b1, a, 8'($urandom));
		end
		foreach (written[i]) begin
			check_mem(written[i]);
		end
		for (int p = 0; p < 4; p++) begin
			read_port(2'(p));
		end

		$display("=== PASS ===");
		$finish;
	end

	// watchdog
	initial begin
		repeat (timeout_cycles) @(posedge clk);
		fail_run("timeout, the test sequence did not finish in time");
	end

endmodule

//--- sim/msx_cart_assertions.sv
/*
 * slot protocol checks for the mapper cartridge
 * slot driver follows n_rd and claimed reads are answered in time
 */

`timescale 1ns/1ps

module msx_cart_assertions (
	input logic clk,
	input logic n_reset,
	input logic [15:0] adr,
	input logic n_sltsl,
	input logic n_rd,
	input logic n_ioreq,
	input logic n_mereq,
	input logic is_output,
	input logic is_output_d
);
	import msx_cart_pkg::*;

	logic mem_claim;
	logic io_claim;
	logic read_claim;

	// memory cycles in pages 1 and 2, i/o cycles on ports FCh to FFh
	assign mem_claim = !n_sltsl && !n_mereq && (adr[15:14] == 2'd1 || adr[15:14] == 2'd2);
	assign io_claim = !n_ioreq && (adr[7:2] == mapper_port_base[7:2]);
	assign read_claim = !n_rd && (mem_claim || io_claim);

	// --------------------------------------------------
	// slot driver
	// --------------------------------------------------
	property drive_needs_rd;
		@(posedge clk) disable iff (!n_reset) is_output |-> !n_rd;
	endproperty

	// enable is gone two edges after n_rd is seen high
	property enable_released;
		@(posedge clk) disable iff (!n_reset) $rose(n_rd) |-> ##2 !is_output_d;
	endproperty

	// first low sample to driven data takes four edges
	property claimed_read_answered;
		@(posedge clk) disable iff (!n_reset) $rose(read_claim) |-> ##4 is_output;
	endproperty

	drive_needs_rd_a: assert property (drive_needs_rd)
		else $error("is_output high while n_rd is high");
	enable_released_a: assert property (enable_released)
		else $error("is_output_d still high two cycles after n_rd rose");
	claimed_read_answered_a: assert property (claimed_read_answered)
		else $error("claimed slot read did not raise is_output within 4 edges");

endmodule

//--- src/msx_cart_top.sv
/*
 * msx mapper cartridge top level
 * slot bus synchronizer feeding the memory mapper
 */

`timescale 1ns/1ps

module msx_cart_top (
	input logic clk,
	input logic n_reset,
	// cartridge slot
	input logic [15:0] adr,
	input logic [7:0] i_data,
	output logic [7:0] o_data,
	output logic is_output,
	output logic is_output_d,
	input logic n_sltsl,
	input logic n_rd,
	input logic n_wr,
	input logic n_ioreq,
	input logic n_mereq
);
	import msx_cart_pkg::*;

	// internal bus between slot logic and mapper
	msx_bus_req_t req;
	msx_bus_rsp_t rsp;

	msx_bus_sync msx_bus_sync_i (
		.clk(clk),
		.n_reset(n_reset),
		.adr(adr),
		.i_data(i_data),
		.o_data(o_data),
		.is_output(is_output),
		.is_output_d(is_output_d),
		.n_sltsl(n_sltsl),
		.n_rd(n_rd),
		.n_wr(n_wr),
		.n_ioreq(n_ioreq),
		.n_mereq(n_mereq),
		.req(req),
		.rsp(rsp)
	);

	msx_mapper msx_mapper_i (
		.clk(clk),
		.n_reset(n_reset),
		.req(req),
		.rsp(rsp)
	);

endmodule

//--- src/msx_mapper.sv
/*
 * msx memory mapper
 * decodes pages 1-2 and ports FCh-FFh, keeps four segment
 * registers and maps cpu pages onto the 128 KB segment ram
 */

`timescale 1ns/1ps

module msx_mapper (
	input logic clk,
	input logic n_reset,
	input msx_cart_pkg::msx_bus_req_t req,
	output msx_cart_pkg::msx_bus_rsp_t rsp
);
	import msx_cart_pkg::*;

	// decode
	logic io_cs;
	logic memory_cs;
	logic [1:0] port_sel;
	logic [1:0] page_sel;
	// segment registers, one per cpu page
	logic [seg_bits-1:0] seg_reg [4];
	// ram side
	logic [ram_addr_bits-1:0] ram_addr;
	logic ram_write;
	logic [7:0] ram_data;
	// read return
	logic ff_read_ready;
	logic ff_read_io;
	logic [7:0] ff_port_data;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	// same word seen as page/offset or as port number
	assign page_sel = req.address.mem.page;
	assign port_sel = req.address.io.port[1:0];

	// four consecutive ports, base is 4-aligned
	assign io_cs = (req.address.io.port[7:2] == mapper_port_base[7:2]);
	// pages 0 and 3 stay with bios and system ram
	assign memory_cs = (page_sel == 2'd1) || (page_sel == 2'd2);

	// --------------------------------------------------
	// segment registers
	// --------------------------------------------------
	// power-on map is 3,2,1,0 like a stock msx2 mapper
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < 4; i++) begin
				seg_reg[i] <= seg_bits'(3 - i);
			end
		end else if (req.write && req.io) begin
			seg_reg[port_sel] <= req.write_data[seg_bits-1:0];
		end
	end

	// --------------------------------------------------
	// segment ram
	// --------------------------------------------------
	// segment of the addressed page on top of the page offset
	assign ram_addr = {seg_reg[page_sel], req.address.mem.offset};
	assign ram_write = req.write & req.memory;

	msx_segment_ram msx_segment_ram_i (
		.clk(clk),
		.addr(ram_addr),
		.write_data(req.write_data),
		.write(ram_write),
		.read_data(ram_data)
	);

	// --------------------------------------------------
	// read return
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
		end else begin
			ff_read_ready <= req.read;
		end
	end

	// port readback, unused upper bits read as 1
	always_ff @(posedge clk) begin
		if (req.read) begin
			ff_read_io <= req.io;
			ff_port_data <= {{(8 - seg_bits){1'b1}}, seg_reg[port_sel]};
		end
	end

	// ram output is valid the cycle after the read pulse, same as ready
	assign rsp = '{
		io_cs: io_cs,
		memory_cs: memory_cs,
		read_ready: ff_read_ready,
		read_data: ff_read_io ? ff_port_data : ram_data
	};

endmodule

//--- src/msx_bus_sync.sv
/*
 * msx slot bus synchronizer
 * samples the asynchronous slot strobes on clk, makes one-cycle
 * internal read/write pulses and drives the slot read data
 */

`timescale 1ns/1ps

module msx_bus_sync (
	input logic clk,
	input logic n_reset,
	// cartridge slot side
	input logic [15:0] adr,
	input logic [7:0] i_data,
	output logic [7:0] o_data,
	output logic is_output,
	output logic is_output_d,
	input logic n_sltsl,
	input logic n_rd,
	input logic n_wr,
	input logic n_ioreq,
	input logic n_mereq,
	// internal bus side
	output msx_cart_pkg::msx_bus_req_t req,
	input msx_cart_pkg::msx_bus_rsp_t rsp
);
	import msx_cart_pkg::*;

	// sampled strobes
	logic ff_n_sltsl;
	logic ff_n_rd;
	logic ff_n_wr;
	logic ff_n_ioreq;
	logic ff_n_mereq;
	// access levels and their delayed copies
	logic w_mem_rd;
	logic w_mem_wr;
	logic w_io_rd;
	logic w_io_wr;
	logic ff_mem_rd;
	logic ff_mem_wr;
	logic ff_io_rd;
	logic ff_io_wr;
	// leading-edge pulses
	logic w_rd_pulse;
	logic w_wr_pulse;
	// latched bus values
	msx_addr_u ff_address;
	logic [7:0] ff_write_data;
	logic [7:0] ff_read_data;
	logic ff_read;
	logic ff_write;
	logic ff_read_en;

	// --------------------------------------------------
	// strobe sampling
	// --------------------------------------------------
	// all strobes idle high out of reset
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_n_sltsl <= 1'b1;
			ff_n_rd <= 1'b1;
			ff_n_wr <= 1'b1;
			ff_n_ioreq <= 1'b1;
			ff_n_mereq <= 1'b1;
		end else begin
			ff_n_sltsl <= n_sltsl;
			ff_n_rd <= n_rd;
			ff_n_wr <= n_wr;
			ff_n_ioreq <= n_ioreq;
			ff_n_mereq <= n_mereq;
		end
	end

	// memory cycles need both the slot select and the memory request
	assign w_mem_rd = ~ff_n_sltsl & ~ff_n_mereq & ~ff_n_rd;
	assign w_mem_wr = ~ff_n_sltsl & ~ff_n_mereq & ~ff_n_wr;
	assign w_io_rd = ~ff_n_ioreq & ~ff_n_rd;
	assign w_io_wr = ~ff_n_ioreq & ~ff_n_wr;

	// --------------------------------------------------
	// pulse generation
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_mem_rd <= 1'b0;
			ff_mem_wr <= 1'b0;
			ff_io_rd <= 1'b0;
			ff_io_wr <= 1'b0;
			ff_read <= 1'b0;
			ff_write <= 1'b0;
		end else begin
			ff_mem_rd <= w_mem_rd;
			ff_mem_wr <= w_mem_wr;
			ff_io_rd <= w_io_rd;
			ff_io_wr <= w_io_wr;
			// one clock late so address is already latched
			ff_read <= w_rd_pulse;
			ff_write <= w_wr_pulse;
		end
	end

	// a long strobe only gives one pulse, on its first sampled cycle
	assign w_rd_pulse = (w_mem_rd & ~ff_mem_rd) | (w_io_rd & ~ff_io_rd);
	assign w_wr_pulse = (w_mem_wr & ~ff_mem_wr) | (w_io_wr & ~ff_io_wr);

	// address and write data are captured with the pulse
	always_ff @(posedge clk) begin
		if (w_rd_pulse || w_wr_pulse) begin
			ff_address <= adr;
		end
		if (w_wr_pulse) begin
			ff_write_data <= i_data;
		end
	end

	// --------------------------------------------------
	// read data return
	// --------------------------------------------------
	// only claimed reads latch data and enable the slot driver
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_data <= 8'd0;
			ff_read_en <= 1'b0;
		end else if (rsp.read_ready && (req.io || req.memory)) begin
			ff_read_data <= rsp.read_data;
			ff_read_en <= 1'b1;
		end else if (ff_n_rd) begin
			ff_read_en <= 1'b0;
		end
	end

	// levels are qualified by the mapper chip selects
	assign req = '{
		address: ff_address,
		write_data: ff_write_data,
		read: ff_read,
		write: ff_write,
		io: (ff_io_rd | ff_io_wr) & rsp.io_cs,
		memory: (ff_mem_rd | ff_mem_wr) & rsp.memory_cs
	};

	assign o_data = ff_read_data;
	// raw n_rd so the driver releases the instant the cpu lets go
	assign is_output = ff_read_en & ~n_rd;
	assign is_output_d = ff_read_en;

endmodule

//--- src/msx_segment_ram.sv
/*
 * segment ram, 128 KB byte wide
 * single port, registered read with one cycle latency
 */

`timescale 1ns/1ps

module msx_segment_ram (
	input logic clk,
	input logic [msx_cart_pkg::ram_addr_bits-1:0] addr,
	input logic [7:0] write_data,
	input logic write,
	output logic [7:0] read_data
);
	import msx_cart_pkg::*;

	// eight 16 KB segments back to back
	logic [7:0] mem [ram_bytes];

	// --------------------------------------------------
	// access
	// --------------------------------------------------
	// read returns the old byte when written in the same cycle
	always_ff @(posedge clk) begin
		if (write) begin
			mem[addr] <= write_data;
		end
		read_data <= mem[addr];
	end

endmodule

//--- src/msx_cart_pkg.sv
/*
 * msx memory mapper cartridge, shared definitions
 * sizes, mapper port numbers, the slot address word and the
 * internal bus request/response structs
 */

package msx_cart_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	// segment number width, eight 16 KB segments
	localparam int seg_bits = 3;
	localparam int seg_count = 8;
	// byte offset inside one 16 KB page
	localparam int offset_bits = 14;
	localparam int ram_addr_bits = seg_bits + offset_bits;
	// total mapped ram, 128 KB
	localparam int ram_bytes = seg_count << offset_bits;

	// ports FCh..FFh select pages 0..3
	localparam logic [7:0] mapper_port_base = 8'hfc;

	// --------------------------------------------------
	// slot address word
	// --------------------------------------------------
	typedef struct packed {
		logic [1:0] page;
		logic [offset_bits-1:0] offset;
	} msx_mem_addr_t;

	// upper byte carries the A register on an OUT (n),A and is ignored
	typedef struct packed {
		logic [7:0] high;
		logic [7:0] port;
	} msx_io_addr_t;

	typedef union packed {
		msx_mem_addr_t mem;
		msx_io_addr_t io;
	} msx_addr_u;

	// --------------------------------------------------
	// internal bus
	// --------------------------------------------------
	// bus block to mapper, read/write are one-cycle pulses
	typedef struct packed {
		msx_addr_u address;
		logic [7:0] write_data;
		logic read;
		logic write;
		logic io;
		logic memory;
	} msx_bus_req_t;

	// mapper to bus block, chip selects are combinational from address
	typedef struct packed {
		logic io_cs;
		logic memory_cs;
		logic read_ready;
		logic [7:0] read_data;
	} msx_bus_rsp_t;

endpackage
